/* requant.f */
+incdir+.
requant_data_pkg.sv
requant_bus_pkg.sv
output_scaler.sv
requant_cfg_regs.sv
requant_engine.sv
wb_arbiter.sv
scratch_mem.sv
requant_top.sv
tb_requant_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_requant_top -f requant.f -o sim_requant
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_requant)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* tb_requant_top.sv */
// Directed testbench for requant_top; needs a simulator with timing support, memory is uninitialized
`timescale 1ns/1ps
`include "requant_consts.svh"

module tb_requant_top;

    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 500;

    logic        clk;
    logic        rst_n;
    logic        cfg_cyc;
    logic        cfg_stb;
    logic        cfg_we;
    logic [2:0]  cfg_adr;
    logic [31:0] cfg_dat_w;
    logic [31:0] cfg_dat_r;
    logic        cfg_ack;
    logic        host_cyc;
    logic        host_stb;
    logic        host_we;
    logic [9:0]  host_adr;
    logic [31:0] host_dat_w;
    logic [31:0] host_dat_r;
    logic        host_ack;

    // Scoreboard state
    int          tests;
    int          checks;
    int          errors;
    int          test_errors_at_start;
    logic [31:0] lfsr;

    // Accumulators of the current job and the words read back
    logic signed [19:0] accs [0:15];
    logic [31:0]        got [0:3];

    // Format the reference model applies
    logic [15:0] m_scale;
    logic [4:0]  m_shift;
    logic [7:0]  m_offset;
    logic        m_uns;
    logic [3:0]  m_bits;

    requant_top requant_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_cyc   (cfg_cyc),
        .cfg_stb   (cfg_stb),
        .cfg_we    (cfg_we),
        .cfg_adr   (cfg_adr),
        .cfg_dat_w (cfg_dat_w),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .host_cyc  (host_cyc),
        .host_stb  (host_stb),
        .host_we   (host_we),
        .host_adr  (host_adr),
        .host_dat_w(host_dat_w),
        .host_dat_r(host_dat_r),
        .host_ack  (host_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic timeout_abort(input string what);
        $display("Timeout: no response while waiting for %s at %0t", what, $time);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // Holds the request until ack, then leaves one idle cycle
    task automatic cfg_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        cfg_cyc = 1'b1;
        cfg_stb = 1'b1;
        cfg_we = we;
        cfg_adr = adr;
        cfg_dat_w = wdata;
        do begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > WAIT_LIMIT) timeout_abort("cfg_ack");
        end while (!cfg_ack);
        rdata = cfg_dat_r;
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        cfg_we = 1'b0;
        @(posedge clk);
        #2;
    endtask

    // Idle cycle lets the arbiter hand the bus to the engine
    task automatic host_access(input logic we, input logic [9:0] adr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        host_cyc = 1'b1;
        host_stb = 1'b1;
        host_we = we;
        host_adr = adr;
        host_dat_w = wdata;
        do begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > WAIT_LIMIT) timeout_abort("host_ack");
        end while (!host_ack);
        rdata = host_dat_r;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic cfg_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        cfg_access(1'b1, adr, data, unused);
    endtask

    task automatic cfg_read(input logic [2:0] adr, output logic [31:0] data);
        cfg_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic host_write(input logic [9:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        host_access(1'b1, adr, data, unused);
    endtask

    task automatic host_read(input logic [9:0] adr, output logic [31:0] data);
        host_access(1'b0, adr, 32'h0, data);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_acc(output logic signed [19:0] v);
        v = '0;
        repeat (20) begin
            lfsr = lfsr_next(lfsr);
            v = {v[18:0], lfsr[0]};
        end
    endtask

    // Scale, floor shifts, zero point, clamp to the format
    function automatic logic [7:0] model_byte(input logic signed [19:0] acc);
        longint v;
        longint hi;
        longint lo;
        v = longint'(acc) * longint'(m_scale);
        v = v >>> 16;
        v = v >>> m_shift;
        v = v + longint'(m_offset);
        if (m_uns) begin
            hi = (longint'(1) << m_bits) - 1;
            lo = 0;
        end else begin
            hi = (longint'(1) << (m_bits - 1)) - 1;
            lo = -(longint'(1) << (m_bits - 1));
        end
        if (v > hi) begin
            v = hi;
        end else if (v < lo) begin
            v = lo;
        end
        return v[7:0];
    endfunction

    // Input 4w+b lands in byte b, missing inputs read as zero
    function automatic logic [31:0] expected_word(input int w, input int n);
        logic [31:0] word;
        int          idx;
        word = '0;
        for (int b = 0; b < 4; b++) begin
            idx = 4 * w + b;
            if (idx < n) word[8*b +: 8] = model_byte(accs[idx]);
        end
        return word;
    endfunction

    task automatic set_format(input logic [15:0] scale, input logic [4:0] shift,
                              input logic [7:0] offset, input logic uns, input logic [3:0] bits);
        m_scale = scale;
        m_shift = shift;
        m_offset = offset;
        m_uns = uns;
        m_bits = bits;
        cfg_write(`REQ_REG_SCALE, {16'h0, scale});
        cfg_write(`REQ_REG_SHIFT, {27'h0, shift});
        cfg_write(`REQ_REG_OFFSET, {24'h0, offset});
        cfg_write(`REQ_REG_FMT, {27'h0, uns, bits});
    endtask

    // Accumulators go in sign-extended, one per word
    task automatic launch_job(input int n, input logic [9:0] src, input logic [9:0] dst);
        for (int i = 0; i < n; i++) begin
            host_write(src + 10'(i), {{12{accs[i][19]}}, accs[i]});
        end
        cfg_write(`REQ_REG_SRC, {22'h0, src});
        cfg_write(`REQ_REG_DST, {22'h0, dst});
        cfg_write(`REQ_REG_LEN, n);
        cfg_write(`REQ_REG_CTRL, 32'h1);
    endtask

    task automatic wait_done;
        logic [31:0] ctrl;
        int          polls;
        polls = 0;
        ctrl = '0;
        while (!ctrl[1]) begin
            polls++;
            if (polls > POLL_LIMIT) timeout_abort("the done flag");
            cfg_read(`REQ_REG_CTRL, ctrl);
        end
        // Engine is back in idle once the flag is seen
        cfg_read(`REQ_REG_CTRL, ctrl);
        check_equal(ctrl, 32'h2, "CTRL after done");
    endtask

    task automatic finish_job(input int n, input logic [9:0] dst);
        logic [31:0] word;
        wait_done();
        for (int w = 0; w < (n + 3) / 4; w++) begin
            host_read(dst + 10'(w), word);
            got[w] = word;
            check_equal(word, expected_word(w, n), $sformatf("output word %0d", w));
        end
        cfg_write(`REQ_REG_CTRL, 32'h2);
    endtask

    task automatic begin_test;
        test_errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors_at_start) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", tests, name, errors - test_errors_at_start);
        end
    endtask

    task automatic roundtrip(input logic [2:0] adr, input logic [31:0] value);
        logic [31:0] data;
        cfg_write(adr, value);
        cfg_read(adr, data);
        check_equal(data, value, $sformatf("register %0d readback", adr));
    endtask

    task automatic test_registers;
        logic [31:0] data;
        begin_test();
        cfg_read(`REQ_REG_CTRL, data);
        check_equal(data, 32'h0, "CTRL after reset");
        // Values stay inside each field width
        roundtrip(`REQ_REG_SCALE, 32'h0000beef);
        roundtrip(`REQ_REG_SHIFT, 32'h00000013);
        roundtrip(`REQ_REG_OFFSET, 32'h0000005a);
        roundtrip(`REQ_REG_FMT, 32'h00000015);
        roundtrip(`REQ_REG_SRC, 32'h000002a5);
        roundtrip(`REQ_REG_DST, 32'h0000015a);
        roundtrip(`REQ_REG_LEN, 32'h000003c3);
        end_test("register readback");
    endtask

    task automatic test_signed8;
        begin_test();
        for (int i = 0; i < 12; i++) begin
            random_acc(accs[i]);
        end
        accs[12] = 20'sh7ffff;
        accs[13] = 20'sh80000;
        set_format(16'h4000, 5'd2, 8'd0, 1'b0, 4'd8);
        launch_job(14, 10'h010, 10'h100);
        finish_job(14, 10'h100);
        // Full scale inputs must clamp to both limits
        check_equal(got[3][7:0], 8'h7f, "positive saturation");
        check_equal(got[3][15:8], 8'h80, "negative saturation");
        end_test("signed 8-bit");
    endtask

    task automatic test_unsigned4;
        begin_test();
        for (int i = 0; i < 3; i++) begin
            random_acc(accs[i]);
        end
        // Word 0 ends on a nonzero byte so stale pack data would show in the padding
        accs[3] = 20'sd8192;
        accs[4] = -20'sd4096;
        accs[5] = 20'sd1000;
        accs[6] = -20'sd600;
        set_format(16'h0100, 5'd0, 8'd3, 1'b1, 4'd4);
        launch_job(7, 10'h040, 10'h140);
        finish_job(7, 10'h140);
        check_equal(got[0][31:24], 8'h0f, "clamp at fifteen");
        check_equal(got[1][7:0], 8'h00, "clamp at zero");
        check_equal(got[1][31:24], 8'h00, "padding byte");
        end_test("unsigned 4-bit");
    endtask

    // Fill value mixes every address bit
    function automatic logic [31:0] region_word(input logic [9:0] adr);
        return 32'h5a3c0000 ^ ({22'h0, adr} * 32'h00010003);
    endfunction

    task automatic test_host_during_run;
        logic [31:0] data;
        begin_test();
        for (int a = 0; a < 8; a++) begin
            host_write(10'h300 + 10'(a), region_word(10'h300 + 10'(a)));
        end
        for (int i = 0; i < 12; i++) begin
            random_acc(accs[i]);
        end
        set_format(16'h2000, 5'd1, 8'h10, 1'b0, 4'd6);
        launch_job(12, 10'h080, 10'h180);
        cfg_read(`REQ_REG_CTRL, data);
        check_equal(data[2], 1'b1, "busy during run");
        // Host traffic competes with the engine here
        for (int a = 0; a < 8; a++) begin
            host_read(10'h300 + 10'(a), data);
            check_equal(data, region_word(10'h300 + 10'(a)), "host region word");
        end
        finish_job(12, 10'h180);
        end_test("host access during run");
    endtask

    task automatic test_zero_length;
        logic [31:0] data;
        begin_test();
        host_write(10'h1c0, 32'hcafef00d);
        cfg_write(`REQ_REG_DST, 32'h1c0);
        cfg_write(`REQ_REG_LEN, 32'h0);
        cfg_write(`REQ_REG_CTRL, 32'h1);
        wait_done();
        host_read(10'h1c0, data);
        check_equal(data, 32'hcafef00d, "dst word untouched");
        cfg_write(`REQ_REG_CTRL, 32'h2);
        cfg_read(`REQ_REG_CTRL, data);
        check_equal(data, 32'h0, "done flag cleared");
        end_test("zero length");
    endtask

    initial begin
        rst_n = 1'b0;
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        cfg_we = 1'b0;
        cfg_adr = '0;
        cfg_dat_w = '0;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we = 1'b0;
        host_adr = '0;
        host_dat_w = '0;
        tests = 0;
        checks = 0;
        errors = 0;
        lfsr = 32'h66857f49;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_registers();
        test_signed8();
        test_unsigned4();
        test_host_during_run();
        test_zero_length();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* requant_top.sv */
// Requant subsystem; the host must hold each Wishbone request until ack and may be stalled by the engine
`timescale 1ns/1ps
`include "requant_consts.svh"

module requant_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_cyc,
    input  logic                 cfg_stb,
    input  logic                 cfg_we,
    input  logic [2:0]           cfg_adr,
    input  logic [`REQ_WB_DW-1:0] cfg_dat_w,
    output logic [`REQ_WB_DW-1:0] cfg_dat_r,
    output logic                 cfg_ack,
    input  logic                 host_cyc,
    input  logic                 host_stb,
    input  logic                 host_we,
    input  logic [`REQ_WB_AW-1:0] host_adr,
    input  logic [`REQ_WB_DW-1:0] host_dat_w,
    output logic [`REQ_WB_DW-1:0] host_dat_r,
    output logic                 host_ack
);
    // Engine control and latched-at-start configuration
    logic                   start;
    logic                   busy;
    logic                   done;
    logic [`REQ_FRAC_W-1:0]  scale;
    logic [`REQ_SHIFT_W-1:0] shift;
    logic [`REQ_ACT_W-1:0]   offset;
    logic                   is_unsigned;
    logic [3:0]             out_bits;
    logic [`REQ_WB_AW-1:0]   src;
    logic [`REQ_WB_AW-1:0]   dst;
    logic [`REQ_WB_AW-1:0]   len;

    // Engine master side
    logic                   eng_cyc;
    logic                   eng_stb;
    logic                   eng_we;
    logic [`REQ_WB_AW-1:0]   eng_adr;
    logic [`REQ_WB_DW-1:0]   eng_dat_w;
    logic [`REQ_WB_DW-1:0]   eng_dat_r;
    logic                   eng_ack;

    // Arbitrated memory side
    logic                   mem_cyc;
    logic                   mem_stb;
    logic                   mem_we;
    logic [`REQ_WB_AW-1:0]   mem_adr;
    logic [`REQ_WB_DW-1:0]   mem_dat_w;
    logic [`REQ_WB_DW-1:0]   mem_dat_r;
    logic                   mem_ack;

    requant_cfg_regs cfg_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_cyc    (cfg_cyc),
        .cfg_stb    (cfg_stb),
        .cfg_we     (cfg_we),
        .cfg_adr    (cfg_adr),
        .cfg_dat_w  (cfg_dat_w),
        .cfg_dat_r  (cfg_dat_r),
        .cfg_ack    (cfg_ack),
        .busy       (busy),
        .done       (done),
        .start      (start),
        .scale      (scale),
        .shift      (shift),
        .offset     (offset),
        .is_unsigned(is_unsigned),
        .out_bits   (out_bits),
        .src        (src),
        .dst        (dst),
        .len        (len)
    );

    requant_engine engine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .scale      (scale),
        .shift      (shift),
        .offset     (offset),
        .is_unsigned(is_unsigned),
        .out_bits   (out_bits),
        .src        (src),
        .dst        (dst),
        .len        (len),
        .busy       (busy),
        .done       (done),
        .eng_cyc    (eng_cyc),
        .eng_stb    (eng_stb),
        .eng_we     (eng_we),
        .eng_adr    (eng_adr),
        .eng_dat_w  (eng_dat_w),
        .eng_dat_r  (eng_dat_r),
        .eng_ack    (eng_ack)
    );

    wb_arbiter arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_cyc  (host_cyc),
        .host_stb  (host_stb),
        .host_we   (host_we),
        .host_adr  (host_adr),
        .host_dat_w(host_dat_w),
        .host_dat_r(host_dat_r),
        .host_ack  (host_ack),
        .eng_cyc   (eng_cyc),
        .eng_stb   (eng_stb),
        .eng_we    (eng_we),
        .eng_adr   (eng_adr),
        .eng_dat_w (eng_dat_w),
        .eng_dat_r (eng_dat_r),
        .eng_ack   (eng_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    scratch_mem mem_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_cyc  (mem_cyc),
        .mem_stb  (mem_stb),
        .mem_we   (mem_we),
        .mem_adr  (mem_adr),
        .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r),
        .mem_ack  (mem_ack)
    );

endmodule

/* scratch_mem.sv */
// Single-port word RAM with one-cycle ack; contents are undefined until written
`timescale 1ns/1ps
`include "requant_consts.svh"

module scratch_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mem_cyc,
    input  logic                     mem_stb,
    input  logic                     mem_we,
    input  requant_bus_pkg::wb_adr_t mem_adr,
    input  requant_bus_pkg::wb_dat_t mem_dat_w,
    output requant_bus_pkg::wb_dat_t mem_dat_r,
    output logic                     mem_ack
);
    import requant_bus_pkg::*;

    wb_dat_t ram [0:(1<<`REQ_WB_AW)-1];
    logic    req;

    // No new request while the previous ack is out
    assign req = mem_cyc & mem_stb & ~mem_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= req;
        end
    end

    // Read returns the old word on a write
    always_ff @(posedge clk) begin
        if (req) begin
            if (mem_we) begin
                ram[mem_adr] <= mem_dat_w;
            end
            mem_dat_r <= ram[mem_adr];
        end
    end

endmodule

/* wb_arbiter.sv */
// Two-master round robin; grant held until the owner drops cyc, each switch costs one idle cycle
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     host_cyc,
    input  logic                     host_stb,
    input  logic                     host_we,
    input  requant_bus_pkg::wb_adr_t host_adr,
    input  requant_bus_pkg::wb_dat_t host_dat_w,
    output requant_bus_pkg::wb_dat_t host_dat_r,
    output logic                     host_ack,
    input  logic                     eng_cyc,
    input  logic                     eng_stb,
    input  logic                     eng_we,
    input  requant_bus_pkg::wb_adr_t eng_adr,
    input  requant_bus_pkg::wb_dat_t eng_dat_w,
    output requant_bus_pkg::wb_dat_t eng_dat_r,
    output logic                     eng_ack,
    output logic                     mem_cyc,
    output logic                     mem_stb,
    output logic                     mem_we,
    output requant_bus_pkg::wb_adr_t mem_adr,
    output requant_bus_pkg::wb_dat_t mem_dat_w,
    input  requant_bus_pkg::wb_dat_t mem_dat_r,
    input  logic                     mem_ack
);
    logic own_host;
    logic own_eng;
    logic last_eng;
    logic host_first;

    // On a tie the host wins only if the engine went last
    assign host_first = host_cyc & (~eng_cyc | last_eng);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_host <= 1'b0;
            own_eng  <= 1'b0;
            last_eng <= 1'b0;
        end else if (!own_host && !own_eng) begin
            if (host_first) begin
                own_host <= 1'b1;
                last_eng <= 1'b0;
            end else if (eng_cyc) begin
                own_eng  <= 1'b1;
                last_eng <= 1'b1;
            end
        end else if ((own_host && !host_cyc) || (own_eng && !eng_cyc)) begin
            // Release into an idle cycle
            own_host <= 1'b0;
            own_eng  <= 1'b0;
        end
    end

    assign mem_cyc   = (own_host & host_cyc) | (own_eng & eng_cyc);
    assign mem_stb   = (own_host & host_stb) | (own_eng & eng_stb);
    assign mem_we    = own_eng ? eng_we : host_we;
    assign mem_adr   = own_eng ? eng_adr : host_adr;
    assign mem_dat_w = own_eng ? eng_dat_w : host_dat_w;

    // The waiting master sees neither ack nor data
    assign host_ack   = own_host & mem_ack;
    assign eng_ack    = own_eng & mem_ack;
    assign host_dat_r = own_host ? mem_dat_r : '0;
    assign eng_dat_r  = own_eng ? mem_dat_r : '0;

endmodule

/* requant_engine.sv */
// Bus-master requantizer; one access at a time, addresses wrap at the memory size, LEN counts words
`timescale 1ns/1ps
`include "requant_consts.svh"

module requant_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  requant_data_pkg::scale_t  scale,
    input  requant_data_pkg::shift_t  shift,
    input  requant_data_pkg::offset_t offset,
    input  logic                      is_unsigned,
    input  requant_data_pkg::obits_t  out_bits,
    input  requant_bus_pkg::wb_adr_t  src,
    input  requant_bus_pkg::wb_adr_t  dst,
    input  requant_bus_pkg::wb_adr_t  len,
    output logic                      busy,
    output logic                      done,
    output logic                      eng_cyc,
    output logic                      eng_stb,
    output logic                      eng_we,
    output requant_bus_pkg::wb_adr_t  eng_adr,
    output requant_bus_pkg::wb_dat_t  eng_dat_w,
    input  requant_bus_pkg::wb_dat_t  eng_dat_r,
    input  logic                      eng_ack
);
    import requant_data_pkg::*;
    import requant_bus_pkg::*;

    eng_state_t state;
    scale_t     scale_q;
    shift_t     shift_q;
    offset_t    offset_q;
    logic       uns_q;
    obits_t     bits_q;
    wb_adr_t    rd_ptr;
    wb_adr_t    wr_ptr;
    wb_adr_t    remain;
    wb_dat_t    pack;
    logic [1:0] slot;
    logic       bus_req;
    logic       xfer;
    logic       sc_valid;
    act_t       sc_y;

    assign xfer      = bus_req & eng_ack;
    assign busy      = (state != IDLE);
    assign done      = (state == FINISH);
    assign eng_cyc   = bus_req;
    assign eng_stb   = bus_req;
    assign eng_we    = (state == STORE);
    assign eng_adr   = eng_we ? wr_ptr : rd_ptr;
    assign eng_dat_w = pack;

    // Fed straight from the read ack
    output_scaler scaler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (xfer && state == FETCH),
        .acc        (acc_t'(eng_dat_r[`REQ_ACC_W-1:0])),
        .scale      (scale_q),
        .shift      (shift_q),
        .offset     (offset_q),
        .is_unsigned(uns_q),
        .out_bits   (bits_q),
        .out_valid  (sc_valid),
        .y          (sc_y)
    );

    // Request drops for the cycle after each ack so the arbiter may switch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_req <= 1'b0;
        end else begin
            bus_req <= (state == FETCH || state == STORE) && !xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:   if (start) state <= (len == '0) ? FINISH : FETCH;
                FETCH:  if (xfer) state <= SCALE;
                // Store on a full word or after the last input
                SCALE:  state <= (slot == 2'd3 || remain == '0) ? STORE : FETCH;
                STORE:  if (xfer) state <= (remain == '0) ? FINISH : FETCH;
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Configuration is frozen for the whole run
        if (state == IDLE && start) begin
            scale_q  <= scale;
            shift_q  <= shift;
            offset_q <= offset;
            uns_q    <= is_unsigned;
            bits_q   <= out_bits;
            rd_ptr   <= src;
            wr_ptr   <= dst;
            remain   <= len;
            pack     <= '0;
            slot     <= '0;
        end
        if (state == FETCH && xfer) begin
            rd_ptr <= rd_ptr + 1'b1;
            remain <= remain - 1'b1;
        end
        // Input i of a group lands in byte i
        if (state == SCALE && sc_valid) begin
            pack[{slot, 3'b000} +: `REQ_ACT_W] <= sc_y;
            slot <= slot + 2'd1;
        end
        // Cleared so a short last group pads with zeros
        if (state == STORE && xfer) begin
            wr_ptr <= wr_ptr + 1'b1;
            pack   <= '0;
            slot   <= '0;
        end
    end

endmodule

/* requant_cfg_regs.sv */
// Config slave; writes during a run apply at the next start, and CTRL bit 1 is write-1-to-clear
`timescale 1ns/1ps
`include "requant_consts.svh"

module requant_cfg_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_cyc,
    input  logic                      cfg_stb,
    input  logic                      cfg_we,
    input  requant_bus_pkg::reg_idx_t cfg_adr,
    input  requant_bus_pkg::wb_dat_t  cfg_dat_w,
    output requant_bus_pkg::wb_dat_t  cfg_dat_r,
    output logic                      cfg_ack,
    input  logic                      busy,
    input  logic                      done,
    output logic                      start,
    output requant_data_pkg::scale_t  scale,
    output requant_data_pkg::shift_t  shift,
    output requant_data_pkg::offset_t offset,
    output logic                      is_unsigned,
    output requant_data_pkg::obits_t  out_bits,
    output requant_bus_pkg::wb_adr_t  src,
    output requant_bus_pkg::wb_adr_t  dst,
    output requant_bus_pkg::wb_adr_t  len
);
    import requant_bus_pkg::*;

    logic    req;
    logic    wr_ctrl;
    logic    done_flag;
    wb_dat_t rd_data;

    // A request counts only while no ack is out
    assign req     = cfg_cyc & cfg_stb & ~cfg_ack;
    assign wr_ctrl = req & cfg_we & (cfg_adr == `REQ_REG_CTRL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_ack   <= 1'b0;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            cfg_ack <= req;
            // Start is ignored while a run is in progress
            start   <= wr_ctrl & cfg_dat_w[0] & ~busy;
            // Done wins over a clear in the same cycle
            if (done) begin
                done_flag <= 1'b1;
            end else if (wr_ctrl && cfg_dat_w[1]) begin
                done_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scale       <= '0;
            shift       <= '0;
            offset      <= '0;
            is_unsigned <= 1'b0;
            out_bits    <= 4'd8;
            src         <= '0;
            dst         <= '0;
            len         <= '0;
        end else if (req && cfg_we) begin
            case (cfg_adr)
                `REQ_REG_SCALE:  scale <= cfg_dat_w[`REQ_FRAC_W-1:0];
                `REQ_REG_SHIFT:  shift <= cfg_dat_w[`REQ_SHIFT_W-1:0];
                `REQ_REG_OFFSET: offset <= cfg_dat_w[`REQ_ACT_W-1:0];
                `REQ_REG_FMT: begin
                    out_bits    <= cfg_dat_w[3:0];
                    is_unsigned <= cfg_dat_w[4];
                end
                `REQ_REG_SRC:    src <= cfg_dat_w[`REQ_WB_AW-1:0];
                `REQ_REG_DST:    dst <= cfg_dat_w[`REQ_WB_AW-1:0];
                `REQ_REG_LEN:    len <= cfg_dat_w[`REQ_WB_AW-1:0];
                default: ;
            endcase
        end
    end

    // FMT packs width in bits 3:0 and the unsigned flag in bit 4
    always_comb begin
        case (cfg_adr)
            `REQ_REG_CTRL:   rd_data = wb_dat_t'({busy, done_flag, 1'b0});
            `REQ_REG_SCALE:  rd_data = wb_dat_t'(scale);
            `REQ_REG_SHIFT:  rd_data = wb_dat_t'(shift);
            `REQ_REG_OFFSET: rd_data = wb_dat_t'(offset);
            `REQ_REG_FMT:    rd_data = wb_dat_t'({is_unsigned, out_bits});
            `REQ_REG_SRC:    rd_data = wb_dat_t'(src);
            `REQ_REG_DST:    rd_data = wb_dat_t'(dst);
            default:         rd_data = wb_dat_t'(len);
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            cfg_dat_r <= rd_data;
        end
    end

endmodule

/* output_scaler.sv */
// One-cycle requantizer; out_bits must lie in 1..8 and rounding is floor toward minus infinity
`timescale 1ns/1ps
`include "requant_consts.svh"

module output_scaler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  requant_data_pkg::acc_t    acc,
    input  requant_data_pkg::scale_t  scale,
    input  requant_data_pkg::shift_t  shift,
    input  requant_data_pkg::offset_t offset,
    input  logic                      is_unsigned,
    input  requant_data_pkg::obits_t  out_bits,
    output logic                      out_valid,
    output requant_data_pkg::act_t    y
);
    import requant_data_pkg::*;

    // Full product plus one sign bit
    localparam int PROD_W = `REQ_ACC_W + `REQ_FRAC_W + 1;

    typedef logic signed [PROD_W-1:0] wide_t;

    logic [`REQ_ACC_W-1:0]             mag;
    logic [`REQ_ACC_W+`REQ_FRAC_W-1:0] mag_prod;
    wide_t                             prod;
    wide_t                             fp_shifted;
    wide_t                             shifted;
    wide_t                             presat;
    wide_t                             sat_hi;
    wide_t                             sat_lo;
    act_t                              y_next;

    always_comb begin
        // Multiply magnitudes so both operands are unsigned
        mag      = acc[`REQ_ACC_W-1] ? -acc : acc;
        mag_prod = mag * scale;
        // Put the sign back on the exact product
        prod = acc[`REQ_ACC_W-1] ? -$signed({1'b0, mag_prod}) : $signed({1'b0, mag_prod});

        // Drop the fraction, then the user shift; both floor
        fp_shifted = prod >>> `REQ_FRAC_W;
        shifted    = fp_shifted >>> shift;
        presat     = shifted + $signed({{(PROD_W-`REQ_ACT_W){1'b0}}, offset});

        // Clamp limits from the output format
        if (is_unsigned) begin
            sat_hi = (wide_t'(1) << out_bits) - wide_t'(1);
            sat_lo = '0;
        end else begin
            sat_hi = (wide_t'(1) << (out_bits - 4'd1)) - wide_t'(1);
            sat_lo = -(wide_t'(1) << (out_bits - 4'd1));
        end

        if (presat > sat_hi) begin
            y_next = sat_hi[`REQ_ACT_W-1:0];
        end else if (presat < sat_lo) begin
            y_next = sat_lo[`REQ_ACT_W-1:0];
        end else begin
            y_next = presat[`REQ_ACT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Result held until the next input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            y <= y_next;
        end
    end

endmodule

/* requant_bus_pkg.sv */
// Wishbone and control types; addresses are word addresses and no byte selects exist
`include "requant_consts.svh"

package requant_bus_pkg;

    // Word address into the scratch memory
    typedef logic [`REQ_WB_AW-1:0] wb_adr_t;
    typedef logic [`REQ_WB_DW-1:0] wb_dat_t;

    // Index into the eight config registers
    typedef logic [2:0] reg_idx_t;

    // Engine sequencing
    typedef enum logic [2:0] {IDLE, FETCH, SCALE, STORE, FINISH} eng_state_t;

endpackage

/* requant_data_pkg.sv */
// Value types of the requant datapath; scale is unsigned Q0.16 and the zero point is unsigned
`include "requant_consts.svh"

package requant_data_pkg;

    // Signed accumulator as the host stores it
    typedef logic signed [`REQ_ACC_W-1:0] acc_t;

    // One packed output byte
    typedef logic [`REQ_ACT_W-1:0] act_t;

    // Fixed-point multiplier and right shift
    typedef logic [`REQ_FRAC_W-1:0] scale_t;
    typedef logic [`REQ_SHIFT_W-1:0] shift_t;

    // Zero point, added zero-extended
    typedef logic [`REQ_ACT_W-1:0] offset_t;

    // Output width, valid from 1 to 8
    typedef logic [3:0] obits_t;

endpackage

/* requant_consts.svh */
// Fixed widths and register map; the memory depth follows REQ_WB_AW and output widths stop at 8
`ifndef REQUANT_CONSTS_SVH
`define REQUANT_CONSTS_SVH

// Datapath widths
`define REQ_ACC_W 20
`define REQ_ACT_W 8
`define REQ_FRAC_W 16
`define REQ_SHIFT_W 5

// Wishbone word address and data
`define REQ_WB_AW 10
`define REQ_WB_DW 32

// Register word indices on the cfg port
`define REQ_REG_CTRL 3'd0
`define REQ_REG_SCALE 3'd1
`define REQ_REG_SHIFT 3'd2
`define REQ_REG_OFFSET 3'd3
`define REQ_REG_FMT 3'd4
`define REQ_REG_SRC 3'd5
`define REQ_REG_DST 3'd6
`define REQ_REG_LEN 3'd7

`endif
